/* source/csr_pkg.sv */
package csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and types
  //////////////////////////////////////////////////////////////////////

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  // top bit flags an interrupt
  typedef logic [5:0]  cause_t;
  typedef logic [1:0]  perf_idx_t;

  // access operation from the decode stage
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // only user and machine exist
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  //////////////////////////////////////////////////////////////////////
  // csr map
  //////////////////////////////////////////////////////////////////////

  localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
  localparam csr_addr_t ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t ADDR_MEPC      = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
  // non-standard, current privilege
  localparam csr_addr_t ADDR_PRIVLV    = 12'hC10;
  localparam csr_addr_t ADDR_PCER      = 12'h7A0;
  localparam csr_addr_t ADDR_PCMR      = 12'h7A1;
  localparam csr_addr_t ADDR_PCCR_ALL  = 12'h79F;
  localparam csr_addr_t ADDR_PCCR_BASE = 12'h780;

  // mstatus field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;
  localparam int MSTATUS_MPP_HI   = 12;

  // register select into the trap block
  localparam logic [1:0] TRAP_SEL_MSTATUS = 2'd0;
  localparam logic [1:0] TRAP_SEL_MEPC    = 2'd1;
  localparam logic [1:0] TRAP_SEL_MCAUSE  = 2'd2;
  localparam logic [1:0] TRAP_SEL_PRIVLV  = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // performance counters
  //////////////////////////////////////////////////////////////////////

  localparam int N_PERF_COUNTERS = 4;
  localparam int PERF_CYCLE      = 0;
  localparam int PERF_INSTR      = 1;
  localparam int PERF_LOAD       = 2;
  localparam int PERF_STORE      = 3;
  // low address bits enough to tell pcer, pcmr and pccr apart
  localparam int PERF_SEL_W      = 6;
  // bit 0 global enable, bit 1 saturate
  localparam logic [1:0] PCMR_RESET = 2'd3;

endpackage

/* source/csr_access_decode.sv */
`timescale 1ns/1ps

module csr_access_decode (
  input  logic                               csr_access_i,
  input  csr_pkg::csr_addr_t                 csr_addr_i,
  input  csr_pkg::csr_op_e                   csr_op_i,
  input  csr_pkg::csr_data_t                 csr_wdata_i,
  input  logic [3:0]                         core_id_i,
  input  logic [5:0]                         cluster_id_i,
  input  logic [23:0]                        boot_addr_i,
  input  csr_pkg::csr_data_t                 trap_rdata_i,
  input  csr_pkg::csr_data_t                 perf_rdata_i,
  output csr_pkg::csr_data_t                 csr_rdata_o,
  output csr_pkg::csr_data_t                 wdata_o,
  output logic [1:0]                         trap_sel_o,
  output logic [csr_pkg::PERF_SEL_W-1:0]     perf_sel_o,
  output logic                               mstatus_we_o,
  output logic                               mepc_we_o,
  output logic                               mcause_we_o,
  output logic                               pcer_we_o,
  output logic                               pcmr_we_o,
  output logic                               pccr_we_o,
  output logic                               pccr_all_o,
  output csr_pkg::perf_idx_t                 pccr_idx_o
);

  // read source flags
  logic               src_trap;
  logic               src_perf;
  csr_pkg::csr_data_t local_rdata;
  // register hits
  logic               is_mstatus;
  logic               is_mepc;
  logic               is_mcause;
  logic               is_pcer;
  logic               is_pcmr;
  logic               is_pccr;
  logic               we;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    trap_sel_o  = csr_pkg::TRAP_SEL_MSTATUS;
    src_trap    = 1'b0;
    src_perf    = 1'b0;
    local_rdata = '0;
    is_mstatus  = 1'b0;
    is_mepc     = 1'b0;
    is_mcause   = 1'b0;
    is_pcer     = 1'b0;
    is_pcmr     = 1'b0;
    is_pccr     = 1'b0;
    pccr_all_o  = 1'b0;
    case (csr_addr_i)
      csr_pkg::ADDR_MSTATUS: begin
        src_trap   = 1'b1;
        is_mstatus = 1'b1;
      end
      csr_pkg::ADDR_MEPC: begin
        src_trap   = 1'b1;
        trap_sel_o = csr_pkg::TRAP_SEL_MEPC;
        is_mepc    = 1'b1;
      end
      csr_pkg::ADDR_MCAUSE: begin
        src_trap   = 1'b1;
        trap_sel_o = csr_pkg::TRAP_SEL_MCAUSE;
        is_mcause  = 1'b1;
      end
      // privilege is read only
      csr_pkg::ADDR_PRIVLV: begin
        src_trap   = 1'b1;
        trap_sel_o = csr_pkg::TRAP_SEL_PRIVLV;
      end
      // hart id from cluster and core
      csr_pkg::ADDR_MHARTID: local_rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      // vector base follows the boot address
      csr_pkg::ADDR_MTVEC:   local_rdata = {boot_addr_i, 8'h0};
      csr_pkg::ADDR_PCER: begin
        src_perf = 1'b1;
        is_pcer  = 1'b1;
      end
      csr_pkg::ADDR_PCMR: begin
        src_perf = 1'b1;
        is_pcmr  = 1'b1;
      end
      // write-all alias reads as zero
      csr_pkg::ADDR_PCCR_ALL: begin
        src_perf   = 1'b1;
        is_pccr    = 1'b1;
        pccr_all_o = 1'b1;
      end
      default: begin
        // four counters from the pccr base
        if (csr_addr_i[11:2] == csr_pkg::ADDR_PCCR_BASE[11:2]) begin
          src_perf = 1'b1;
          is_pccr  = 1'b1;
        end
      end
    endcase
  end

  assign perf_sel_o = csr_addr_i[csr_pkg::PERF_SEL_W-1:0];
  assign pccr_idx_o = csr_addr_i[1:0];

  // read mux with zero for unknown addresses
  assign csr_rdata_o = src_trap ? trap_rdata_i :
                       src_perf ? perf_rdata_i : local_rdata;

  //////////////////////////////////////////////////////////////////////
  // read-modify-write
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_op_i)
      csr_pkg::CSR_OP_SET:   wdata_o = csr_rdata_o | csr_wdata_i;
      csr_pkg::CSR_OP_CLEAR: wdata_o = csr_rdata_o & ~csr_wdata_i;
      default:               wdata_o = csr_wdata_i;
    endcase
  end

  // strobes only on a real access
  assign we = csr_access_i && (csr_op_i != csr_pkg::CSR_OP_NONE);

  assign mstatus_we_o = we & is_mstatus;
  assign mepc_we_o    = we & is_mepc;
  assign mcause_we_o  = we & is_mcause;
  assign pcer_we_o    = we & is_pcer;
  assign pcmr_we_o    = we & is_pcmr;
  assign pccr_we_o    = we & is_pccr;

endmodule

/* source/csr_trap_ctrl.sv */
`timescale 1ns/1ps

module csr_trap_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_data_t    wdata_i,
  input  logic [1:0]            sel_i,
  input  logic                  mstatus_we_i,
  input  logic                  mepc_we_i,
  input  logic                  mcause_we_i,
  output csr_pkg::csr_data_t    rdata_o,
  input  csr_pkg::csr_data_t    pc_if_i,
  input  csr_pkg::csr_data_t    pc_id_i,
  input  logic                  csr_save_if_i,
  input  logic                  csr_save_id_i,
  input  logic                  csr_save_cause_i,
  input  csr_pkg::cause_t       csr_cause_i,
  input  logic                  csr_restore_mret_i,
  output csr_pkg::csr_data_t    epc_o,
  output csr_pkg::priv_lvl_e    priv_lvl_o,
  output logic                  m_irq_enable_o,
  output logic                  u_irq_enable_o
);

  // privilege state
  csr_pkg::priv_lvl_e priv_q, priv_d;
  // mstatus fields
  logic               mie_q, mie_d;
  logic               mpie_q, mpie_d;
  csr_pkg::priv_lvl_e mpp_q, mpp_d;
  csr_pkg::csr_data_t mepc_q, mepc_d;
  csr_pkg::cause_t    mcause_q, mcause_d;
  csr_pkg::csr_data_t exc_pc;
  csr_pkg::csr_data_t mstatus_rdata;
  // user interrupts not supported, uie hardwired low
  logic               uie;

  assign uie = 1'b0;

  // pc to save, fetch stage or decode stage
  assign exc_pc = csr_save_if_i ? pc_if_i : pc_id_i;

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    priv_d   = priv_q;
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mpp_d    = mpp_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // plain csr writes
    if (mstatus_we_i) begin
      mie_d  = wdata_i[csr_pkg::MSTATUS_MIE_BIT];
      mpie_d = wdata_i[csr_pkg::MSTATUS_MPIE_BIT];
      // anything but M maps to U
      mpp_d  = (wdata_i[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] ==
                csr_pkg::PRIV_LVL_M) ? csr_pkg::PRIV_LVL_M : csr_pkg::PRIV_LVL_U;
    end
    if (mepc_we_i) begin
      mepc_d = wdata_i;
    end
    if (mcause_we_i) begin
      mcause_d = {wdata_i[31], wdata_i[4:0]};
    end

    // trap entry wins over csr writes
    if (csr_save_cause_i) begin
      mepc_d   = exc_pc;
      mcause_d = csr_cause_i;
      mpie_d   = (priv_q == csr_pkg::PRIV_LVL_U) ? uie : mie_q;
      mie_d    = 1'b0;
      mpp_d    = priv_q;
      // every trap lands in M
      priv_d   = csr_pkg::PRIV_LVL_M;
    end else if (csr_restore_mret_i) begin
      priv_d = mpp_q;
      // returning to U would load uie, which is not kept
      if (mpp_q == csr_pkg::PRIV_LVL_M) begin
        mie_d = mpie_q;
      end
      mpie_d = 1'b1;
      mpp_d  = csr_pkg::PRIV_LVL_U;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priv_q   <= csr_pkg::PRIV_LVL_M;
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mpp_q    <= csr_pkg::PRIV_LVL_M;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      priv_q   <= priv_d;
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mpp_q    <= mpp_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read back and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_rdata = '0;
    mstatus_rdata[csr_pkg::MSTATUS_MIE_BIT]  = mie_q;
    mstatus_rdata[csr_pkg::MSTATUS_MPIE_BIT] = mpie_q;
    mstatus_rdata[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = mpp_q;
  end

  always_comb begin
    case (sel_i)
      csr_pkg::TRAP_SEL_MEPC:   rdata_o = mepc_q;
      // interrupt flag at bit 31
      csr_pkg::TRAP_SEL_MCAUSE: rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      csr_pkg::TRAP_SEL_PRIVLV: rdata_o = {30'b0, priv_q};
      default:                  rdata_o = mstatus_rdata;
    endcase
  end

  assign epc_o          = mepc_q;
  assign priv_lvl_o     = priv_q;
  assign m_irq_enable_o = mie_q & (priv_q == csr_pkg::PRIV_LVL_M);
  assign u_irq_enable_o = uie & (priv_q == csr_pkg::PRIV_LVL_U);

  // controller never saves and returns in one cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_save_cause_i && csr_restore_mret_i));

  // one pc source per trap
  assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_save_if_i && csr_save_id_i));

endmodule

/* source/csr_perf_counters.sv */
`timescale 1ns/1ps

module csr_perf_counters (
  input  logic                               clk,
  input  logic                               rst_n,
  input  csr_pkg::csr_data_t                 wdata_i,
  input  logic [csr_pkg::PERF_SEL_W-1:0]     sel_i,
  input  logic                               pcer_we_i,
  input  logic                               pcmr_we_i,
  input  logic                               pccr_we_i,
  input  logic                               pccr_all_i,
  input  csr_pkg::perf_idx_t                 pccr_idx_i,
  output csr_pkg::csr_data_t                 rdata_o,
  input  logic                               id_valid_i,
  input  logic                               is_decoding_i,
  input  logic                               mem_load_i,
  input  logic                               mem_store_i
);

  localparam int N = csr_pkg::N_PERF_COUNTERS;
  localparam int W = csr_pkg::PERF_SEL_W;

  logic [N-1:0]       event_in;
  // qualified event and its registered copy
  logic [N-1:0]       inc;
  logic [N-1:0]       inc_q;
  logic [N-1:0]       pcer_q;
  logic [1:0]         pcmr_q;
  csr_pkg::csr_data_t cnt_q [N];
  csr_pkg::csr_data_t cnt_d [N];

  //////////////////////////////////////////////////////////////////////
  // events
  //////////////////////////////////////////////////////////////////////

  assign event_in[csr_pkg::PERF_CYCLE] = 1'b1;
  // instruction leaves decode
  assign event_in[csr_pkg::PERF_INSTR] = id_valid_i & is_decoding_i;
  assign event_in[csr_pkg::PERF_LOAD]  = mem_load_i;
  assign event_in[csr_pkg::PERF_STORE] = mem_store_i;

  // per-counter enable and global enable
  assign inc = event_in & pcer_q & {N{pcmr_q[0]}};

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < N; i++) begin
      cnt_d[i] = cnt_q[i];
      // hold at all ones when saturating
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // csr write beats the increment
      if (pccr_we_i && (pccr_all_i || (pccr_idx_i == i))) begin
        cnt_d[i] = wdata_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inc_q  <= '0;
      pcer_q <= '0;
      pcmr_q <= csr_pkg::PCMR_RESET;
      for (int i = 0; i < N; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      inc_q <= inc;
      if (pcer_we_i) begin
        pcer_q <= wdata_i[N-1:0];
      end
      if (pcmr_we_i) begin
        pcmr_q <= wdata_i[1:0];
      end
      for (int i = 0; i < N; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // local read, only own registers
  always_comb begin
    rdata_o = '0;
    if (sel_i == csr_pkg::ADDR_PCER[W-1:0]) begin
      rdata_o[N-1:0] = pcer_q;
    end else if (sel_i == csr_pkg::ADDR_PCMR[W-1:0]) begin
      rdata_o[1:0] = pcmr_q;
    end else if (sel_i[W-1:2] == csr_pkg::ADDR_PCCR_BASE[W-1:2]) begin
      rdata_o = cnt_q[sel_i[1:0]];
    end
  end

  // saturated counter holds unless software rewrites it
  for (genvar g = 0; g < N; g++) begin : g_sat_chk
    assert property (@(posedge clk) disable iff (!rst_n)
      ((cnt_q[g] == '1) && pcmr_q[1] &&
       !(pccr_we_i && (pccr_all_i || (pccr_idx_i == g))))
      |=> (cnt_q[g] == '1));
  end

endmodule

/* source/csr_top.sv */
`timescale 1ns/1ps

module csr_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // identity and boot
  input  logic [3:0]            core_id_i,
  input  logic [5:0]            cluster_id_i,
  input  logic [23:0]           boot_addr_i,
  // csr access
  input  logic                  csr_access_i,
  input  csr_pkg::csr_addr_t    csr_addr_i,
  input  csr_pkg::csr_op_e      csr_op_i,
  input  csr_pkg::csr_data_t    csr_wdata_i,
  output csr_pkg::csr_data_t    csr_rdata_o,
  // trap control
  input  csr_pkg::csr_data_t    pc_if_i,
  input  csr_pkg::csr_data_t    pc_id_i,
  input  logic                  csr_save_if_i,
  input  logic                  csr_save_id_i,
  input  logic                  csr_save_cause_i,
  input  csr_pkg::cause_t       csr_cause_i,
  input  logic                  csr_restore_mret_i,
  output csr_pkg::csr_data_t    epc_o,
  output logic [23:0]           mtvec_o,
  output csr_pkg::priv_lvl_e    priv_lvl_o,
  output logic                  m_irq_enable_o,
  output logic                  u_irq_enable_o,
  // events
  input  logic                  id_valid_i,
  input  logic                  is_decoding_i,
  input  logic                  mem_load_i,
  input  logic                  mem_store_i
);

  csr_pkg::csr_data_t                 wdata;
  csr_pkg::csr_data_t                 trap_rdata;
  csr_pkg::csr_data_t                 perf_rdata;
  logic [1:0]                         trap_sel;
  logic [csr_pkg::PERF_SEL_W-1:0]     perf_sel;
  logic                               mstatus_we;
  logic                               mepc_we;
  logic                               mcause_we;
  logic                               pcer_we;
  logic                               pcmr_we;
  logic                               pccr_we;
  logic                               pccr_all;
  csr_pkg::perf_idx_t                 pccr_idx;

  // trap vector is fixed to boot address
  assign mtvec_o = boot_addr_i;

  csr_access_decode i_csr_access_decode (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .boot_addr_i  (boot_addr_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .csr_rdata_o  (csr_rdata_o),
    .wdata_o      (wdata),
    .trap_sel_o   (trap_sel),
    .perf_sel_o   (perf_sel),
    .mstatus_we_o (mstatus_we),
    .mepc_we_o    (mepc_we),
    .mcause_we_o  (mcause_we),
    .pcer_we_o    (pcer_we),
    .pcmr_we_o    (pcmr_we),
    .pccr_we_o    (pccr_we),
    .pccr_all_o   (pccr_all),
    .pccr_idx_o   (pccr_idx)
  );

  csr_trap_ctrl i_csr_trap_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .wdata_i            (wdata),
    .sel_i              (trap_sel),
    .mstatus_we_i       (mstatus_we),
    .mepc_we_i          (mepc_we),
    .mcause_we_i        (mcause_we),
    .rdata_o            (trap_rdata),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_cause_i        (csr_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .epc_o              (epc_o),
    .priv_lvl_o         (priv_lvl_o),
    .m_irq_enable_o     (m_irq_enable_o),
    .u_irq_enable_o     (u_irq_enable_o)
  );

  csr_perf_counters i_csr_perf_counters (
    .clk           (clk),
    .rst_n         (rst_n),
    .wdata_i       (wdata),
    .sel_i         (perf_sel),
    .pcer_we_i     (pcer_we),
    .pcmr_we_i     (pcmr_we),
    .pccr_we_i     (pccr_we),
    .pccr_all_i    (pccr_all),
    .pccr_idx_i    (pccr_idx),
    .rdata_o       (perf_rdata),
    .id_valid_i    (id_valid_i),
    .is_decoding_i (is_decoding_i),
    .mem_load_i    (mem_load_i),
    .mem_store_i   (mem_store_i)
  );

endmodule

/* verif/csr_tb.sv */
`timescale 1ns/1ps

module csr_tb;

  localparam int SETTLE_LIMIT = 20;

  logic                  clk;
  logic                  rst_n;
  logic [3:0]            core_id_i;
  logic [5:0]            cluster_id_i;
  logic [23:0]           boot_addr_i;
  logic                  csr_access_i;
  csr_pkg::csr_addr_t    csr_addr_i;
  csr_pkg::csr_op_e      csr_op_i;
  csr_pkg::csr_data_t    csr_wdata_i;
  csr_pkg::csr_data_t    csr_rdata_o;
  csr_pkg::csr_data_t    pc_if_i;
  csr_pkg::csr_data_t    pc_id_i;
  logic                  csr_save_if_i;
  logic                  csr_save_id_i;
  logic                  csr_save_cause_i;
  csr_pkg::cause_t       csr_cause_i;
  logic                  csr_restore_mret_i;
  csr_pkg::csr_data_t    epc_o;
  logic [23:0]           mtvec_o;
  csr_pkg::priv_lvl_e    priv_lvl_o;
  logic                  m_irq_enable_o;
  logic                  u_irq_enable_o;
  logic                  id_valid_i;
  logic                  is_decoding_i;
  logic                  mem_load_i;
  logic                  mem_store_i;

  // reference model state
  logic                  mie_m;
  logic                  mpie_m;
  csr_pkg::priv_lvl_e    mpp_m;
  csr_pkg::priv_lvl_e    priv_m;
  csr_pkg::csr_data_t    mepc_m;
  csr_pkg::csr_data_t    mcause_m;
  logic [3:0]            pcer_m;
  logic [1:0]            pcmr_m;
  csr_pkg::csr_data_t    cnt_m [4];

  // read check request
  logic                  rd_chk;
  csr_pkg::csr_data_t    rd_exp;
  int                    errors = 0;
  int                    timeouts = 0;

  csr_top i_csr_top (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // read data in the access cycle
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    rd_chk |-> (csr_rdata_o === rd_exp))
    else begin
      errors++;
      $display("error at %0t: read of %h returned %h, expected %h", $time,
               $sampled(csr_addr_i), $sampled(csr_rdata_o), $sampled(rd_exp));
    end

  a_priv: assert property (@(posedge clk) disable iff (!rst_n)
    priv_lvl_o === priv_m)
    else begin
      errors++;
      $display("error at %0t: privilege level differs from model", $time);
    end

  // machine irq enable only counts in M
  a_m_irq: assert property (@(posedge clk) disable iff (!rst_n)
    m_irq_enable_o === (mie_m && (priv_m == csr_pkg::PRIV_LVL_M)))
    else begin
      errors++;
      $display("error at %0t: m_irq_enable_o differs from model", $time);
    end

  a_u_irq: assert property (@(posedge clk) disable iff (!rst_n)
    u_irq_enable_o === 1'b0)
    else begin
      errors++;
      $display("error at %0t: u_irq_enable_o not low", $time);
    end

  a_epc: assert property (@(posedge clk) disable iff (!rst_n)
    (epc_o === mepc_m) && (mtvec_o === boot_addr_i))
    else begin
      errors++;
      $display("error at %0t: epc_o or mtvec_o differs from model", $time);
    end

  //////////////////////////////////////////////////////////////////////
  // model rules
  //////////////////////////////////////////////////////////////////////

  function automatic csr_pkg::csr_data_t apply_op(input csr_pkg::csr_data_t old_v,
                                                  input csr_pkg::csr_data_t data,
                                                  input csr_pkg::csr_op_e op);
    case (op)
      csr_pkg::CSR_OP_SET:   return old_v | data;
      csr_pkg::CSR_OP_CLEAR: return old_v & ~data;
      default:               return data;
    endcase
  endfunction

  function automatic csr_pkg::csr_data_t expected_read(input csr_pkg::csr_addr_t addr);
    csr_pkg::csr_data_t v;
    v = '0;
    case (addr)
      csr_pkg::ADDR_MSTATUS: begin
        v[3]     = mie_m;
        v[7]     = mpie_m;
        v[12:11] = mpp_m;
      end
      csr_pkg::ADDR_MEPC:     v = mepc_m;
      csr_pkg::ADDR_MCAUSE:   v = mcause_m;
      csr_pkg::ADDR_PRIVLV:   v = {30'b0, priv_m};
      csr_pkg::ADDR_MHARTID:  v = {21'b0, cluster_id_i, 1'b0, core_id_i};
      csr_pkg::ADDR_MTVEC:    v = {boot_addr_i, 8'h00};
      csr_pkg::ADDR_PCER:     v = {28'b0, pcer_m};
      csr_pkg::ADDR_PCMR:     v = {30'b0, pcmr_m};
      default: begin
        // counters sit at 0x780..0x783
        if (addr[11:2] == 10'h1E0) begin
          v = cnt_m[addr[1:0]];
        end
      end
    endcase
    return v;
  endfunction

  function automatic void update_regs(input csr_pkg::csr_addr_t addr,
                                      input csr_pkg::csr_data_t val);
    case (addr)
      csr_pkg::ADDR_MSTATUS: begin
        mie_m  = val[3];
        mpie_m = val[7];
        mpp_m  = (val[12:11] == 2'b11) ? csr_pkg::PRIV_LVL_M : csr_pkg::PRIV_LVL_U;
      end
      csr_pkg::ADDR_MEPC:     mepc_m = val;
      // only interrupt flag and low code bits exist
      csr_pkg::ADDR_MCAUSE:   mcause_m = val & 32'h8000_001F;
      csr_pkg::ADDR_PCER:     pcer_m = val[3:0];
      csr_pkg::ADDR_PCMR:     pcmr_m = val[1:0];
      csr_pkg::ADDR_PCCR_ALL: begin
        for (int i = 0; i < 4; i++) begin
          cnt_m[i] = val;
        end
      end
      default: begin
        if (addr[11:2] == 10'h1E0) begin
          cnt_m[addr[1:0]] = val;
        end
      end
    endcase
  endfunction

  // enabled event saturates or wraps
  function automatic void count_event(input int idx);
    if (pcer_m[idx] && pcmr_m[0]) begin
      if (!(pcmr_m[1] && (cnt_m[idx] == '1))) begin
        cnt_m[idx] = cnt_m[idx] + 1;
      end
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic release_inputs();
    csr_access_i       = 1'b0;
    csr_op_i           = csr_pkg::CSR_OP_NONE;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_save_cause_i   = 1'b0;
    csr_restore_mret_i = 1'b0;
    id_valid_i         = 1'b0;
    is_decoding_i      = 1'b0;
    mem_load_i         = 1'b0;
    mem_store_i        = 1'b0;
    rd_chk             = 1'b0;
  endtask

  // old value must come back in the same cycle
  task automatic write_csr(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_e op,
                           input csr_pkg::csr_data_t data);
    csr_pkg::csr_data_t old_v;
    old_v        = expected_read(addr);
    csr_access_i = 1'b1;
    csr_addr_i   = addr;
    csr_op_i     = op;
    csr_wdata_i  = data;
    rd_exp       = old_v;
    rd_chk       = 1'b1;
    next_cycle();
    if (op != csr_pkg::CSR_OP_NONE) begin
      update_regs(addr, apply_op(old_v, data, op));
    end
    release_inputs();
  endtask

  task automatic read_csr(input csr_pkg::csr_addr_t addr);
    write_csr(addr, csr_pkg::CSR_OP_NONE, $urandom);
  endtask

  task automatic take_trap(input logic from_if, input csr_pkg::csr_data_t pc,
                           input csr_pkg::cause_t cause);
    csr_save_cause_i = 1'b1;
    csr_cause_i      = cause;
    csr_save_if_i    = from_if;
    csr_save_id_i    = !from_if;
    // the unused pc differs so a wrong pick shows
    pc_if_i          = from_if ? pc : ~pc;
    pc_id_i          = from_if ? ~pc : pc;
    next_cycle();
    mepc_m   = pc;
    mcause_m = {cause[5], 26'b0, cause[4:0]};
    // uie is always 0 when trapping from U
    mpie_m   = (priv_m == csr_pkg::PRIV_LVL_U) ? 1'b0 : mie_m;
    mie_m    = 1'b0;
    mpp_m    = priv_m;
    priv_m   = csr_pkg::PRIV_LVL_M;
    release_inputs();
  endtask

  task automatic do_mret();
    csr_restore_mret_i = 1'b1;
    next_cycle();
    if (mpp_m == csr_pkg::PRIV_LVL_M) begin
      mie_m = mpie_m;
    end
    priv_m = mpp_m;
    mpie_m = 1'b1;
    mpp_m  = csr_pkg::PRIV_LVL_U;
    release_inputs();
  endtask

  task automatic pulse_events(input int n);
    for (int i = 0; i < n; i++) begin
      mem_load_i    = $urandom % 2;
      mem_store_i   = $urandom % 2;
      id_valid_i    = $urandom % 2;
      is_decoding_i = $urandom % 2;
      next_cycle();
      count_event(csr_pkg::PERF_CYCLE);
      if (id_valid_i && is_decoding_i) begin
        count_event(csr_pkg::PERF_INSTR);
      end
      if (mem_load_i) begin
        count_event(csr_pkg::PERF_LOAD);
      end
      if (mem_store_i) begin
        count_event(csr_pkg::PERF_STORE);
      end
    end
    release_inputs();
  endtask

  // poll a counter until the event pipeline has drained
  task automatic wait_count(input csr_pkg::csr_addr_t addr);
    int waited;
    waited       = 0;
    csr_access_i = 1'b1;
    csr_addr_i   = addr;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
    #1;
    while ((csr_rdata_o !== expected_read(addr)) && (waited < SETTLE_LIMIT)) begin
      next_cycle();
      waited++;
    end
    if (csr_rdata_o !== expected_read(addr)) begin
      timeouts++;
      $display("timeout: counter at %h never reached the expected count", addr);
    end
    release_inputs();
  endtask

  task automatic check_counters();
    for (int i = 0; i < 4; i++) begin
      wait_count(csr_pkg::ADDR_PCCR_BASE + i);
      read_csr(csr_pkg::ADDR_PCCR_BASE + i);
    end
  endtask

  initial begin
    void'($urandom(57));
    clk          = 1'b0;
    rst_n        = 1'b0;
    core_id_i    = 4'h5;
    cluster_id_i = 6'h2A;
    boot_addr_i  = 24'h1C_0080;
    csr_addr_i   = '0;
    csr_wdata_i  = '0;
    csr_cause_i  = '0;
    pc_if_i      = '0;
    pc_id_i      = '0;
    release_inputs();
    mie_m    = 1'b0;
    mpie_m   = 1'b0;
    mpp_m    = csr_pkg::PRIV_LVL_M;
    priv_m   = csr_pkg::PRIV_LVL_M;
    mepc_m   = '0;
    mcause_m = '0;
    pcer_m   = '0;
    pcmr_m   = 2'd3;
    for (int i = 0; i < 4; i++) begin
      cnt_m[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset values and identity
    read_csr(csr_pkg::ADDR_MSTATUS);
    read_csr(csr_pkg::ADDR_PRIVLV);
    read_csr(csr_pkg::ADDR_PCMR);
    read_csr(csr_pkg::ADDR_PCER);
    read_csr(csr_pkg::ADDR_MHARTID);
    read_csr(csr_pkg::ADDR_MTVEC);

    // random read-modify-write on mepc and mcause
    for (int i = 0; i < 12; i++) begin
      write_csr(csr_pkg::ADDR_MEPC, csr_pkg::csr_op_e'(1 + $urandom % 3), $urandom);
      read_csr(csr_pkg::ADDR_MEPC);
      write_csr(csr_pkg::ADDR_MCAUSE, csr_pkg::csr_op_e'(1 + $urandom % 3), $urandom);
      read_csr(csr_pkg::ADDR_MCAUSE);
    end
    // unmapped address and read-only mtvec
    write_csr(12'h123, csr_pkg::CSR_OP_WRITE, $urandom);
    read_csr(12'h123);
    write_csr(csr_pkg::ADDR_MTVEC, csr_pkg::CSR_OP_WRITE, $urandom);
    read_csr(csr_pkg::ADDR_MTVEC);

    ////////////////////////////////////////////////////////////////////
    // trap and return in M
    ////////////////////////////////////////////////////////////////////
    write_csr(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_OP_SET, 32'h8);
    take_trap(1'b0, $urandom, 6'h0B);
    read_csr(csr_pkg::ADDR_MEPC);
    read_csr(csr_pkg::ADDR_MCAUSE);
    read_csr(csr_pkg::ADDR_MSTATUS);
    do_mret();
    read_csr(csr_pkg::ADDR_MSTATUS);

    // drop to U through mpp and trap back
    write_csr(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_OP_SET, 32'h1800);
    write_csr(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_OP_CLEAR, 32'h1800);
    do_mret();
    read_csr(csr_pkg::ADDR_PRIVLV);
    take_trap(1'b1, $urandom, 6'h27);
    read_csr(csr_pkg::ADDR_MSTATUS);
    read_csr(csr_pkg::ADDR_PRIVLV);
    read_csr(csr_pkg::ADDR_MCAUSE);
    read_csr(csr_pkg::ADDR_MEPC);

    ////////////////////////////////////////////////////////////////////
    // performance counters
    ////////////////////////////////////////////////////////////////////
    write_csr(csr_pkg::ADDR_PCER, csr_pkg::CSR_OP_WRITE, 32'hC);
    pulse_events(40);
    check_counters();
    // saturation at all ones
    write_csr(csr_pkg::ADDR_PCCR_BASE + 2, csr_pkg::CSR_OP_WRITE, '1);
    pulse_events(10);
    check_counters();
    write_csr(csr_pkg::ADDR_PCCR_ALL, csr_pkg::CSR_OP_WRITE, $urandom);
    check_counters();

    $display("checks done: %0d value errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src.f */
source/csr_pkg.sv
source/csr_access_decode.sv
source/csr_trap_ctrl.sv
source/csr_perf_counters.sv
source/csr_top.sv
verif/csr_tb.sv

/* Bender.yml */
package:
  name: csr_block

sources:
  - source/csr_pkg.sv
  - source/csr_access_decode.sv
  - source/csr_trap_ctrl.sv
  - source/csr_perf_counters.sv
  - source/csr_top.sv
  - target: test
    files:
      - verif/csr_tb.sv
